/* Bender.yml */
package:
  name: dmr_top

dependencies: {}

sources:
  - hdl/dmr_pkg.sv
  - hdl/op_issue.sv
  - hdl/acc_core.sv
  - hdl/dmr_checker.sv
  - hdl/dmr_top.sv
  - target: test
    files:
      - tb/tb_dmr_top.sv

/* hdl/acc_core.sv */
`timescale 1ns/1ps
// Two-stage accumulator core, one operation per cycle, never stalls
// Result appears two cycles after the operation is presented
module acc_core import dmr_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    op_valid_i,
  input  opcode_t op_code_i,
  input  word_t   op_data_i,
  output logic    res_valid_o,
  output word_t   res_data_o
);

  logic        s1_valid_q;
  opcode_t     s1_code_q;
  word_t       s1_data_q;
  word_t       acc_q;
  word_t       acc_d;
  logic [63:0] rot_wide;

  // Stage 1 control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= op_valid_i;
    end
  end

  // Stage 1 operands
  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      s1_code_q <= op_code_i;
      s1_data_q <= op_data_i;
    end
  end

  // Upper half of the doubled word is the rotated value
  assign rot_wide = {acc_q, acc_q} << s1_data_q[4:0];

  always_comb begin
    case (s1_code_q)
      OP_ADD:  acc_d = acc_q + s1_data_q;
      OP_XOR:  acc_d = acc_q ^ s1_data_q;
      OP_LOAD: acc_d = s1_data_q;
      default: acc_d = rot_wide[63:32];
    endcase
  end

  // Stage 2, accumulator doubles as the result register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q       <= '0;
      res_valid_o <= 1'b0;
    end else begin
      if (s1_valid_q) begin
        acc_q <= acc_d;
      end
      res_valid_o <= s1_valid_q;
    end
  end

  assign res_data_o = acc_q;

endmodule

/* hdl/dmr_checker.sv */
`timescale 1ns/1ps
// Lockstep result checker with tagged output buffer
// Core 0 result is forwarded, the flag marks any disagreement
// Buffer overflow is prevented upstream by the issuer
module dmr_checker import dmr_pkg::*; #(
  parameter int unsigned OutDepth   = 4,
  parameter int unsigned OutCredits = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     res0_valid_i,
  input  word_t    res0_data_i,
  input  logic     res1_valid_i,
  input  word_t    res1_data_i,
  input  logic     res_credit_i,
  output logic     res_valid_o,
  output word_t    res_data_o,
  output logic     res_err_o,
  output logic     res_sent_o,
  output err_cnt_t err_count_o
);

  localparam int unsigned PtrW = (OutDepth > 1) ? $clog2(OutDepth) : 1;
  localparam int unsigned CntW = $clog2(OutDepth + 1);
  localparam int unsigned CrdW = $clog2(OutCredits + 1);

  word_t           buf_data_q [OutDepth];
  logic            buf_err_q  [OutDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] buf_cnt_q;
  logic [CrdW-1:0] credit_q;
  err_cnt_t        err_cnt_q;
  logic            wr_en;
  logic            mismatch;
  logic            send;

  // A valid on only one side also counts as a mismatch
  assign wr_en    = res0_valid_i || res1_valid_i;
  assign mismatch = (res0_valid_i != res1_valid_i) || (res0_data_i != res1_data_i);

  // Send from the head whenever a credit is held
  assign send        = (buf_cnt_q != '0) && (credit_q != '0);
  assign res_sent_o  = send;
  assign err_count_o = err_cnt_q;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      buf_data_q[wr_ptr_q] <= res0_data_i;
      buf_err_q[wr_ptr_q]  <= mismatch;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      buf_cnt_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(OutDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (send) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(OutDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      buf_cnt_q <= buf_cnt_q + CntW'(wr_en) - CntW'(send);
    end
  end

  // Output credits and saturating error count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q  <= CrdW'(OutCredits);
      err_cnt_q <= '0;
    end else begin
      credit_q <= credit_q + CrdW'(res_credit_i) - CrdW'(send);
      if (wr_en && mismatch && (err_cnt_q != '1)) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  // Registered output port
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= send;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      res_data_o <= buf_data_q[rd_ptr_q];
      res_err_o  <= buf_err_q[rd_ptr_q];
    end
  end

endmodule

/* hdl/dmr_pkg.sv */
// Shared types and opcode encodings for the DMR accumulator subsystem
// Every opcode returns the new accumulator value as its result
// ROTL uses only the low 5 bits of the operand
package dmr_pkg;

  // Operand and result word
  typedef logic [31:0] word_t;

  // Operation code, see constants below
  typedef logic [1:0] opcode_t;

  // Mismatch count, saturates at all ones
  typedef logic [15:0] err_cnt_t;

  // acc = acc + operand
  localparam opcode_t OP_ADD  = 2'd0;

  // acc = acc ^ operand
  localparam opcode_t OP_XOR  = 2'd1;

  // acc = operand
  localparam opcode_t OP_LOAD = 2'd2;

  // acc = acc rotated left by operand[4:0]
  localparam opcode_t OP_ROTL = 2'd3;

endpackage

/* hdl/dmr_top.sv */
`timescale 1ns/1ps
// DMR accumulator subsystem with credit-based input and output
// fault_mask_i corrupts core 1 results only, for checker self-test
// Sender starts with InDepth credits, receiver grants OutCredits
module dmr_top import dmr_pkg::*; #(
  parameter int unsigned InDepth    = 4,
  parameter int unsigned OutDepth   = 4,
  parameter int unsigned OutCredits = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     op_valid_i,
  input  opcode_t  op_code_i,
  input  word_t    op_data_i,
  input  word_t    fault_mask_i,
  input  logic     res_credit_i,
  output logic     in_credit_o,
  output logic     res_valid_o,
  output word_t    res_data_o,
  output logic     res_err_o,
  output err_cnt_t err_count_o
);

  logic    iss_valid;
  opcode_t iss_code;
  word_t   iss_data;
  logic    res0_valid;
  word_t   res0_data;
  logic    res1_valid;
  word_t   res1_data_raw;
  word_t   res1_data;
  logic    res_sent;

  op_issue #(
    .InDepth  ( InDepth  ),
    .OutDepth ( OutDepth )
  ) u_issue (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .op_valid_i  ( op_valid_i  ),
    .op_code_i   ( op_code_i   ),
    .op_data_i   ( op_data_i   ),
    .res_sent_i  ( res_sent    ),
    .in_credit_o ( in_credit_o ),
    .iss_valid_o ( iss_valid   ),
    .iss_code_o  ( iss_code    ),
    .iss_data_o  ( iss_data    )
  );

  acc_core u_core0 (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .op_valid_i  ( iss_valid  ),
    .op_code_i   ( iss_code   ),
    .op_data_i   ( iss_data   ),
    .res_valid_o ( res0_valid ),
    .res_data_o  ( res0_data  )
  );

  acc_core u_core1 (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .op_valid_i  ( iss_valid     ),
    .op_code_i   ( iss_code      ),
    .op_data_i   ( iss_data      ),
    .res_valid_o ( res1_valid    ),
    .res_data_o  ( res1_data_raw )
  );

  // Fault injection on the compare path only
  assign res1_data = res1_data_raw ^ fault_mask_i;

  dmr_checker #(
    .OutDepth   ( OutDepth   ),
    .OutCredits ( OutCredits )
  ) u_checker (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .res0_valid_i ( res0_valid   ),
    .res0_data_i  ( res0_data    ),
    .res1_valid_i ( res1_valid   ),
    .res1_data_i  ( res1_data    ),
    .res_credit_i ( res_credit_i ),
    .res_valid_o  ( res_valid_o  ),
    .res_data_o   ( res_data_o   ),
    .res_err_o    ( res_err_o    ),
    .res_sent_o   ( res_sent     ),
    .err_count_o  ( err_count_o  )
  );

endmodule

/* hdl/op_issue.sv */
`timescale 1ns/1ps
// Input operation FIFO and issue stage feeding both cores
// The sender must stay within its credits; a full FIFO is not guarded
// Issue stalls once OutDepth results are in flight or buffered
module op_issue import dmr_pkg::*; #(
  parameter int unsigned InDepth  = 4,
  parameter int unsigned OutDepth = 4
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    op_valid_i,
  input  opcode_t op_code_i,
  input  word_t   op_data_i,
  input  logic    res_sent_i,
  output logic    in_credit_o,
  output logic    iss_valid_o,
  output opcode_t iss_code_o,
  output word_t   iss_data_o
);

  localparam int unsigned PtrW = (InDepth > 1) ? $clog2(InDepth) : 1;
  localparam int unsigned CntW = $clog2(InDepth + 1);
  localparam int unsigned OutW = $clog2(OutDepth + 1);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    FULL_WAIT
  } iss_state_e;

  iss_state_e state_q, state_d;

  opcode_t         fifo_code_q [InDepth];
  word_t           fifo_data_q [InDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] fifo_cnt_q;
  logic [OutW-1:0] outst_q;
  logic            fifo_empty;
  logic            room;
  logic            pop;

  assign fifo_empty  = (fifo_cnt_q == '0);
  // Space left in the checker buffer for one more result
  assign room        = (outst_q < OutW'(OutDepth));
  assign pop         = !fifo_empty && room;
  assign in_credit_o = pop;
  assign iss_valid_o = (state_q == ISSUE);

  // FIFO storage
  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      fifo_code_q[wr_ptr_q] <= op_code_i;
      fifo_data_q[wr_ptr_q] <= op_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
      outst_q    <= '0;
    end else begin
      if (op_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(InDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(InDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + CntW'(op_valid_i) - CntW'(pop);
      // Issued but not yet sent out
      outst_q    <= outst_q + OutW'(pop) - OutW'(res_sent_i);
    end
  end

  // Issue FSM, ISSUE marks a valid operation on the core bus
  always_comb begin
    if (pop) begin
      state_d = ISSUE;
    end else if (!fifo_empty) begin
      state_d = FULL_WAIT;
    end else begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Issue payload, same word to both cores
  always_ff @(posedge clk_i) begin
    if (pop) begin
      iss_code_o <= fifo_code_q[rd_ptr_q];
      iss_data_o <= fifo_data_q[rd_ptr_q];
    end
  end

endmodule

/* src.f */
hdl/dmr_pkg.sv
hdl/op_issue.sv
hdl/acc_core.sv
hdl/dmr_checker.sv
hdl/dmr_top.sv
tb/tb_dmr_top.sv

/* tb/tb_dmr_top.sv */
`timescale 1ns/1ps
// Random-stimulus testbench for dmr_top with a queue-based accumulator model
// Outputs are sampled on the rising edge and inputs are driven on the falling edge
// The fault mask only changes while the DUT is drained
module tb_dmr_top import dmr_pkg::*; ();

  localparam int unsigned InDepth    = 4;
  localparam int unsigned OutDepth   = 4;
  localparam int unsigned OutCredits = 2;
  localparam int ResetCycles = 16;
  localparam int TotalOps    = 200 + 60 + 40 + 16;
  localparam int HoldWindow  = 8 * (InDepth + OutDepth + OutCredits);
  localparam int CredPrompt  = 0;
  localparam int CredRandom  = 1;
  localparam int CredHold    = 2;

  logic clk_i = 1'b0;
  logic rst_n_i, op_valid_i, res_credit_i, in_credit_o, res_valid_o, res_err_o;
  opcode_t  op_code_i;
  word_t    op_data_i, fault_mask_i, res_data_o;
  err_cnt_t err_count_o;

  integer seed = 32'h85ea1646;
  int     checks, errors, ops_left, ops_accepted, result_count, in_credit_count;
  int     sender_credits = InDepth;
  int     credit_owed, credit_mode;
  word_t  model_acc;
  word_t  exp_data_q[$];
  logic   exp_err_q[$];

  dmr_top #(
    .InDepth    ( InDepth    ),
    .OutDepth   ( OutDepth   ),
    .OutCredits ( OutCredits )
  ) dut (.*);

  always #4 clk_i = ~clk_i;

  // Reference accumulator rules
  function automatic word_t apply_op(input word_t acc, input opcode_t code, input word_t data);
    int sh;
    sh = data[4:0];
    case (code)
      OP_ADD:  return acc + data;
      OP_XOR:  return acc ^ data;
      OP_LOAD: return data;
      default: return (acc << sh) | (acc >> (32 - sh));
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Wait until every accepted operation has returned and all credits went back
  task automatic drain_dut();
    do @(posedge clk_i); while (ops_left != 0 || exp_data_q.size() != 0 || credit_owed != 0);
    @(posedge clk_i);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, errors - errs_before);
  endtask

  // Output monitor and model compare
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (in_credit_o) begin
        in_credit_count++;
        sender_credits++;
      end
      if (res_valid_o) begin
        result_count++;
        credit_owed++;
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("Result arrived with no operation outstanding at %0t", $time);
        end else begin
          check_value("res_data_o", res_data_o, exp_data_q.pop_front());
          check_value("res_err_o", res_err_o, exp_err_q.pop_front());
        end
      end
    end
  end

  // Sender and receiver act once per falling edge
  always @(negedge clk_i) begin
    op_valid_i   = 1'b0;
    res_credit_i = 1'b0;
    if (credit_owed > 0 && (credit_mode == CredPrompt ||
        (credit_mode == CredRandom && ($random(seed) & 3) == 0))) begin
      res_credit_i = 1'b1;
      credit_owed--;
    end
    if (ops_left > 0 && sender_credits > 0 && ($random(seed) & 3) != 0) begin
      op_code_i  = opcode_t'($random(seed));
      op_data_i  = $random(seed);
      op_valid_i = 1'b1;
      model_acc  = apply_op(model_acc, op_code_i, op_data_i);
      exp_data_q.push_back(model_acc);
      exp_err_q.push_back(fault_mask_i != '0);
      sender_credits--;
      ops_left--;
      ops_accepted++;
    end
  end

  initial begin
    int       errs_before;
    int       res_before;
    err_cnt_t cnt_before;
    rst_n_i      = 1'b0;
    op_valid_i   = 1'b0;
    op_code_i    = '0;
    op_data_i    = '0;
    fault_mask_i = '0;
    res_credit_i = 1'b0;
    model_acc    = '0;
    credit_mode  = CredPrompt;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i) rst_n_i = 1'b1;
    @(posedge clk_i);
    errs_before = errors;
    check_value("res_valid_o", res_valid_o, 0);
    check_value("in_credit_o", in_credit_o, 0);
    check_value("err_count_o", err_count_o, 0);
    report_test("Test 1 reset state", errs_before);

    errs_before = errors;
    ops_left = 200;
    drain_dut();
    check_value("err_count_o", err_count_o, 0);
    report_test("Test 2 arithmetic stream", errs_before);

    errs_before = errors;
    @(negedge clk_i) fault_mask_i = $random(seed) | 32'h1;
    @(posedge clk_i);
    credit_mode = CredRandom;
    cnt_before  = err_count_o;
    ops_left    = 60;
    drain_dut();
    // Every result of the masked run carries a mismatch
    check_value("err_count_o", err_count_o, cnt_before + 60);
    @(negedge clk_i) fault_mask_i = '0;
    @(posedge clk_i);
    cnt_before = err_count_o;
    ops_left   = 40;
    drain_dut();
    check_value("err_count_o", err_count_o, cnt_before);
    report_test("Test 3 fault injection", errs_before);

    // Withheld credits must stall the sender without losing anything
    errs_before = errors;
    credit_mode = CredHold;
    res_before  = result_count;
    ops_left    = 16;
    while (sender_credits != 0) @(posedge clk_i);
    repeat (HoldWindow) @(posedge clk_i);
    if (result_count - res_before > OutCredits || ops_left == 0 || sender_credits != 0) begin
      errors++;
      $display("Back-pressure did not stall the sender as expected");
    end
    credit_mode = CredRandom;
    drain_dut();
    report_test("Test 4 output back-pressure", errs_before);

    errs_before = errors;
    check_value("in_credit_count", in_credit_count, ops_accepted);
    check_value("result_count", result_count, ops_accepted);
    check_value("sender_credits", sender_credits, InDepth);
    report_test("Test 5 credit accounting", errs_before);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the operation count
  initial begin
    repeat (ResetCycles + TotalOps * 40 + HoldWindow) @(posedge clk_i);
    $display("Watchdog timeout, the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule
